// ==== hw/muldiv_pkg.sv ====
`default_nettype none

package muldiv_pkg;

  //////////////////////////////////////////////////
  // Widths and step counts
  //////////////////////////////////////////////////

  // Operand and result width
  localparam int XLEN = 32;

  // Booth radix-4 retires two multiplier bits per step
  localparam int MUL_STEPS = 16;
  // Non-restoring retires one quotient bit per step
  localparam int DIV_STEPS = 32;

  // Step counter must hold DIV_STEPS
  localparam int STEP_CNT_W = 6;

  // Booth adder, 33-bit extended operand plus 2x headroom
  localparam int MUL_ADD_W = 35;
  // Divider adder, 33-bit partial remainder plus sign
  localparam int DIV_ADD_W = 34;

  typedef logic [XLEN-1:0] xlen_t;

  //////////////////////////////////////////////////
  // Opcodes and sequencer states
  //////////////////////////////////////////////////

  // Top bit set marks the divide class
  typedef enum logic [2:0] {
    OP_MUL    = 3'd0,
    OP_MULH   = 3'd1,
    OP_MULHSU = 3'd2,
    OP_MULHU  = 3'd3,
    OP_DIV    = 3'd4,
    OP_DIVU   = 3'd5,
    OP_REM    = 3'd6,
    OP_REMU   = 3'd7
  } muldiv_op_e;

  typedef enum logic [2:0] {
    ST_IDLE      = 3'd0,
    ST_EXEC      = 3'd1,
    ST_REMD_CHCK = 3'd2,
    ST_QUOT_CORR = 3'd3,
    ST_REMD_CORR = 3'd4
  } muldiv_state_e;

endpackage

`default_nettype wire

// ==== hw/muldiv_step_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// Per-cycle step controls shared by sequencer, counter and both datapaths
interface muldiv_step_if;

  // Sequencer phase flags
  logic first;
  logic run;
  logic is_mul;
  logic chck;
  logic quot_corr;
  logic remd_corr;

  // From the step counter
  logic last;

  // From the divider
  logic need_corr;
  logic special;

  modport fsm (output first, run, is_mul, chck, quot_corr, remd_corr,
               input  last, need_corr, special);

  modport cnt (input first, run, is_mul, output last);

  modport div (input  first, run, last, is_mul, chck, quot_corr, remd_corr,
               output need_corr, special);

  modport mul (input first, run, last);

endinterface

`default_nettype wire

// ==== hw/muldiv_fsm.sv ====
`timescale 1ns/100ps
`default_nettype none

module muldiv_fsm import muldiv_pkg::*; (
  input  wire         clk,
  input  wire         i_rst_n,
  input  wire         i_valid,
  input  wire         i_ready,
  input  wire         i_is_div,
  output logic        o_valid,
  output logic        o_ready,
  muldiv_step_if.fsm  step
);

  muldiv_state_e state;
  muldiv_state_e state_nxt;

  // Cycle in which the result may be handed out
  logic res_pt;
  logic hsk;

  // Idle only answers a special case that is actually presented
  assign res_pt = ((state == ST_IDLE) & i_valid & step.special)
                | ((state == ST_EXEC) & step.last & ~i_is_div)
                | ((state == ST_REMD_CHCK) & ~step.need_corr)
                | (state == ST_REMD_CORR);

  // Result leaves only while the operation is still presented
  assign o_valid = res_pt & i_valid;
  // Operation is accepted together with its result
  assign o_ready = res_pt & i_ready;
  assign hsk     = o_valid & i_ready;

  //////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE: begin
        // Special cases retire here without leaving idle
        if (i_valid & ~step.special) state_nxt = ST_EXEC;
      end
      ST_EXEC: begin
        if (step.last) begin
          if (i_is_div) state_nxt = ST_REMD_CHCK;
          else if (hsk) state_nxt = ST_IDLE;
        end
      end
      ST_REMD_CHCK: begin
        if (step.need_corr) state_nxt = ST_QUOT_CORR;
        else if (hsk) state_nxt = ST_IDLE;
      end
      // Quotient fix is always followed by the remainder fix
      ST_QUOT_CORR: state_nxt = ST_REMD_CORR;
      ST_REMD_CORR: begin
        if (hsk) state_nxt = ST_IDLE;
      end
      default: state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Step controls to counter and datapaths
  assign step.first     = (state == ST_IDLE) & i_valid & ~step.special;
  assign step.run       = (state == ST_EXEC);
  assign step.is_mul    = ~i_is_div;
  assign step.chck      = (state == ST_REMD_CHCK);
  assign step.quot_corr = (state == ST_QUOT_CORR);
  assign step.remd_corr = (state == ST_REMD_CORR);

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  a_state_legal: assert property (@(posedge clk) disable iff (!i_rst_n)
    state inside {ST_IDLE, ST_EXEC, ST_REMD_CHCK, ST_QUOT_CORR, ST_REMD_CORR});

  a_valid_needs_op: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_valid |-> i_valid);

  a_quot_then_remd: assert property (@(posedge clk) disable iff (!i_rst_n)
    (state == ST_QUOT_CORR) |=> (state == ST_REMD_CORR));

endmodule

`default_nettype wire

// ==== hw/muldiv_step_counter.sv ====
`timescale 1ns/100ps
`default_nettype none

module muldiv_step_counter import muldiv_pkg::*; (
  input  wire         clk,
  input  wire         i_rst_n,
  muldiv_step_if.cnt  step
);

  logic [STEP_CNT_W-1:0] cnt;
  logic [STEP_CNT_W-1:0] cnt_end;

  // Multiply needs half the steps of divide
  assign cnt_end = step.is_mul ? STEP_CNT_W'(MUL_STEPS) : STEP_CNT_W'(DIV_STEPS);

  // Final execute step
  assign step.last = step.run & (cnt == cnt_end);

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      cnt <= '0;
    end else if (step.first) begin
      // Load cycle already counts as step 0
      cnt <= STEP_CNT_W'(1);
    end else if (step.run & ~step.last) begin
      cnt <= cnt + 1'b1;
    end
  end

  // Holds at the final step while the result waits
  a_cnt_range: assert property (@(posedge clk) disable iff (!i_rst_n)
    cnt <= STEP_CNT_W'(DIV_STEPS));

endmodule

`default_nettype wire

// ==== hw/booth_mul_path.sv ====
`timescale 1ns/100ps
`default_nettype none

module booth_mul_path import muldiv_pkg::*; (
  input  wire         clk,
  input  wire         i_rst_n,
  input  xlen_t       i_rs1,
  input  xlen_t       i_rs2,
  input  wire         i_rs1_signed,
  input  wire         i_rs2_signed,
  input  wire         i_low_half,
  muldiv_step_if.mul  step,
  output xlen_t       o_result
);

  logic                 s1;
  logic                 s2;
  logic [XLEN:0]        prdt_hi;
  logic [XLEN:0]        prdt_lo;
  logic                 prdt_sft1;
  logic [2:0]           booth_code;
  logic                 sel_zero;
  logic                 sel_two;
  logic                 sel_sub;
  logic [MUL_ADD_W-1:0] mcand;
  logic [MUL_ADD_W-1:0] add_op1;
  logic [MUL_ADD_W-1:0] add_op2;
  logic [MUL_ADD_W-1:0] add_res;
  logic                 prdt_ena;

  // Extension bits of both operands
  assign s1 = i_rs1_signed & i_rs1[XLEN-1];
  assign s2 = i_rs2_signed & i_rs2[XLEN-1];

  //////////////////////////////////////////////////
  // Booth radix-4 recode of rs1
  //////////////////////////////////////////////////

  // Last digit takes the extension bit as its top
  assign booth_code = step.first ? {i_rs1[1:0], 1'b0}
                    : step.last  ? {s1, prdt_lo[0], prdt_sft1}
                    :              {prdt_lo[1:0], prdt_sft1};

  // 000 and 111 add nothing, 011 and 100 are the 2x digits
  assign sel_zero = (booth_code == 3'b000) | (booth_code == 3'b111);
  assign sel_two  = (booth_code == 3'b011) | (booth_code == 3'b100);
  assign sel_sub  = booth_code[2];

  assign mcand   = {{(MUL_ADD_W-XLEN){s2}}, i_rs2};
  assign add_op2 = sel_zero ? '0 : sel_two ? (mcand << 1) : mcand;
  // Partial high word, sign extended for the adder
  assign add_op1 = step.first ? '0 : {{(MUL_ADD_W-XLEN-1){prdt_hi[XLEN]}}, prdt_hi};
  assign add_res = sel_sub ? (add_op1 - add_op2) : (add_op1 + add_op2);

  // Hold on the final step so the result stays put
  assign prdt_ena = step.first | (step.run & ~step.last);

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      prdt_hi   <= '0;
      prdt_lo   <= '0;
      prdt_sft1 <= 1'b0;
    end else if (prdt_ena) begin
      prdt_hi   <= add_res[MUL_ADD_W-1:2];
      // Two product bits enter on top, multiplier bits drain below
      prdt_lo   <= {add_res[1:0], step.first ? {s1, i_rs1[XLEN-1:2]} : prdt_lo[XLEN:2]};
      prdt_sft1 <= step.first ? i_rs1[1] : prdt_lo[1];
    end
  end

  // High word comes straight from the last adder pass
  assign o_result = i_low_half ? prdt_lo[XLEN:1] : add_res[XLEN-1:0];

endmodule

`default_nettype wire

// ==== hw/nonrestore_div_path.sv ====
`timescale 1ns/100ps
`default_nettype none

module nonrestore_div_path import muldiv_pkg::*; (
  input  wire         clk,
  input  wire         i_rst_n,
  input  xlen_t       i_rs1,
  input  xlen_t       i_rs2,
  input  wire         i_signed,
  input  wire         i_want_rem,
  muldiv_step_if.div  step,
  output xlen_t       o_result
);

  logic                 s1;
  logic                 s2;
  logic [DIV_ADD_W-1:0] divisor;
  logic                 quot_0cycl;
  logic [XLEN:0]        remd_r;
  logic [XLEN:0]        quot_r;
  logic                 remd_sft1_r;
  logic                 prev_quot;
  logic                 cur_quot;
  logic [DIV_ADD_W-1:0] add_op1;
  logic [DIV_ADD_W-1:0] add_op2;
  logic                 add_sub;
  logic [DIV_ADD_W-1:0] add_res;
  logic [XLEN:0]        quot_low;
  logic                 remd_inc_quot_dec;
  logic                 div_by_0;
  logic                 div_ovf;
  xlen_t                special_res;
  xlen_t                quot_out;
  xlen_t                remd_out;

  assign s1      = i_signed & i_rs1[XLEN-1];
  assign s2      = i_signed & i_rs2[XLEN-1];
  assign divisor = {s2, s2, i_rs2};

  // First quotient digit is -1 when the signs differ
  assign quot_0cycl = ~(s1 ^ s2);
  assign prev_quot  = step.first ? quot_0cycl : quot_r[0];

  // Lower half of the shifted dividend/quotient pair
  assign quot_low = step.first ? {i_rs1, quot_0cycl} : quot_r;

  // Remainder sign opposite to the divisor means quotient too large
  assign remd_inc_quot_dec = remd_r[XLEN] ^ divisor[DIV_ADD_W-1];

  //////////////////////////////////////////////////
  // Shared adder for step, check and corrections
  //////////////////////////////////////////////////

  always_comb begin
    add_op1 = step.first ? {DIV_ADD_W{s1}} : {remd_sft1_r, remd_r};
    add_op2 = divisor;
    add_sub = prev_quot;
    if (step.chck) begin
      // Remainder plus divisor, zero flags remd == -divisor
      add_op1 = {remd_r[XLEN], remd_r};
      add_sub = 1'b0;
    end else if (step.quot_corr) begin
      add_op1 = {quot_r[XLEN], quot_r};
      add_op2 = DIV_ADD_W'(1);
      add_sub = remd_inc_quot_dec;
    end else if (step.remd_corr) begin
      add_op1 = {remd_r[XLEN], remd_r};
      add_sub = ~remd_inc_quot_dec;
    end
  end

  assign add_res  = add_sub ? (add_op1 - add_op2) : (add_op1 + add_op2);
  assign cur_quot = ~(add_res[DIV_ADD_W-1] ^ divisor[DIV_ADD_W-1]);

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      remd_r      <= '0;
      quot_r      <= '0;
      remd_sft1_r <= 1'b0;
    end else begin
      if (step.first | step.run) begin
        // Top adder bit is kept for the next shifted pass
        remd_sft1_r <= add_res[XLEN];
        if (step.last) begin
          // Final pass keeps the unshifted remainder
          remd_r <= add_res[XLEN:0];
          quot_r <= {quot_low[XLEN-1:0], 1'b1};
        end else begin
          remd_r <= {add_res[XLEN-1:0], quot_low[XLEN]};
          quot_r <= {quot_low[XLEN-1:0], cur_quot};
        end
      end else if (step.quot_corr) begin
        quot_r <= add_res[XLEN:0];
      end
    end
  end

  // Check cycle decides whether both corrections are needed
  assign step.need_corr = step.chck & (
      ((remd_r[XLEN] ^ s1) & (|remd_r))
    | (add_res == '0)
    | (remd_r == divisor[XLEN:0]));

  //////////////////////////////////////////////////
  // Special cases, answered from the live operands
  //////////////////////////////////////////////////

  assign div_by_0 = (i_rs2 == '0);
  assign div_ovf  = i_signed & (&i_rs2) & (i_rs1 == {1'b1, {(XLEN-1){1'b0}}});

  assign step.special = ~step.is_mul & (div_by_0 | div_ovf);

  always_comb begin
    if (div_by_0) begin
      special_res = i_want_rem ? i_rs1 : '1;
    end else begin
      special_res = i_want_rem ? '0 : {1'b1, {(XLEN-1){1'b0}}};
    end
  end

  // Remainder fix is not registered, it leaves straight from the adder
  assign quot_out = quot_r[XLEN-1:0];
  assign remd_out = step.remd_corr ? add_res[XLEN-1:0] : remd_r[XLEN-1:0];

  assign o_result = step.special ? special_res : (i_want_rem ? remd_out : quot_out);

endmodule

`default_nettype wire

// ==== hw/muldiv_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module muldiv_unit import muldiv_pkg::*; (
  input  wire         clk,
  input  wire         i_rst_n,
  input  wire         i_valid,
  output logic        o_ready,
  input  muldiv_op_e  i_op,
  input  xlen_t       i_rs1,
  input  xlen_t       i_rs2,
  output logic        o_valid,
  input  wire         i_ready,
  output xlen_t       o_result
);

  logic  op_is_div;
  logic  mul_rs1_signed;
  logic  mul_rs2_signed;
  logic  mul_low_half;
  logic  div_signed;
  logic  div_want_rem;
  xlen_t mul_result;
  xlen_t div_result;

  //////////////////////////////////////////////////
  // Opcode decode
  //////////////////////////////////////////////////

  assign op_is_div = i_op[2];

  // MULHU is the only multiply with unsigned rs1
  assign mul_rs1_signed = (i_op != OP_MULHU);
  // MULHSU and MULHU treat rs2 as unsigned
  assign mul_rs2_signed = (i_op == OP_MUL) | (i_op == OP_MULH);
  assign mul_low_half   = (i_op == OP_MUL);

  assign div_signed   = (i_op == OP_DIV) | (i_op == OP_REM);
  assign div_want_rem = (i_op == OP_REM) | (i_op == OP_REMU);

  muldiv_step_if u_step ();

  muldiv_fsm u_fsm (
    .clk      (clk),
    .i_rst_n  (i_rst_n),
    .i_valid  (i_valid),
    .i_ready  (i_ready),
    .i_is_div (op_is_div),
    .o_valid  (o_valid),
    .o_ready  (o_ready),
    .step     (u_step.fsm)
  );

  muldiv_step_counter u_cnt (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .step    (u_step.cnt)
  );

  booth_mul_path u_mul (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_rs1        (i_rs1),
    .i_rs2        (i_rs2),
    .i_rs1_signed (mul_rs1_signed),
    .i_rs2_signed (mul_rs2_signed),
    .i_low_half   (mul_low_half),
    .step         (u_step.mul),
    .o_result     (mul_result)
  );

  nonrestore_div_path u_div (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_rs1      (i_rs1),
    .i_rs2      (i_rs2),
    .i_signed   (div_signed),
    .i_want_rem (div_want_rem),
    .step       (u_step.div),
    .o_result   (div_result)
  );

  // Special result already folded into the divider output
  assign o_result = op_is_div ? div_result : mul_result;

endmodule

`default_nettype wire

// ==== bench/tb_muldiv_tasks.svh ====
`ifndef TB_MULDIV_TASKS_SVH
`define TB_MULDIV_TASKS_SVH

//////////////////////////////////////////////////
// Stimulus and reference
//////////////////////////////////////////////////

// Galois LFSR stepped once per bit taken
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  logic        b;
  v = '0;
  for (int i = 0; i < n; i++) begin
    b    = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) lfsr = lfsr ^ LFSR_TAPS;
    v = {v[30:0], b};
  end
  return v;
endfunction

function automatic xlen_t rand_word();
  return rand_bits(32);
endfunction

// Random nonzero divisor shifted down so quotients vary in size
function automatic xlen_t rand_divisor();
  xlen_t d;
  d = rand_word();
  d = d >> rand_bits(5);
  return (d == '0) ? 32'h1 : d;
endfunction

function automatic logic is_div_op(input muldiv_op_e op);
  return (op == OP_DIV) || (op == OP_DIVU) || (op == OP_REM) || (op == OP_REMU);
endfunction

// Divide by zero or signed MIN / -1
function automatic logic is_special(input muldiv_op_e op, input xlen_t a, input xlen_t b);
  logic sgn;
  sgn = (op == OP_DIV) || (op == OP_REM);
  return is_div_op(op) && ((b == '0) || (sgn && a == 32'h8000_0000 && b == '1));
endfunction

// RISC-V M-extension result rules
function automatic xlen_t ref_result(input muldiv_op_e op, input xlen_t a, input xlen_t b);
  logic [63:0] ea;
  logic [63:0] eb;
  logic [63:0] prod;
  logic        sgn;
  logic        want_rem;
  logic        neg_a;
  logic        neg_b;
  xlen_t       mag_a;
  xlen_t       mag_b;
  xlen_t       q;
  xlen_t       r;
  // rs1 is signed except in MULHU and rs2 only in MUL and MULH
  ea   = (op != OP_MULHU) ? {{32{a[31]}}, a} : {32'h0, a};
  eb   = (op == OP_MUL || op == OP_MULH) ? {{32{b[31]}}, b} : {32'h0, b};
  prod = ea * eb;
  if (op == OP_MUL) return prod[31:0];
  if (!is_div_op(op)) return prod[63:32];
  sgn      = (op == OP_DIV) || (op == OP_REM);
  want_rem = (op == OP_REM) || (op == OP_REMU);
  if (b == '0) return want_rem ? a : 32'hFFFF_FFFF;
  if (sgn && a == 32'h8000_0000 && b == '1) return want_rem ? 32'h0 : 32'h8000_0000;
  // Truncate toward zero and give the remainder the dividend's sign
  neg_a = sgn & a[31];
  neg_b = sgn & b[31];
  mag_a = neg_a ? -a : a;
  mag_b = neg_b ? -b : b;
  q     = mag_a / mag_b;
  r     = mag_a % mag_b;
  if (neg_a ^ neg_b) q = -q;
  if (neg_a) r = -r;
  return want_rem ? r : q;
endfunction

//////////////////////////////////////////////////
// Check and operation driver
//////////////////////////////////////////////////

task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
  if (exp !== act) begin
    errors++;
    $display("Error: %s expected %h actual %h", name, exp, act);
    $display("Test failures found");
    $fatal(1, "stopped at first mismatch");
  end
endtask

// Runs one operation right after the previous one and holds i_ready low for stall cycles
task automatic run_op(input string name, input muldiv_op_e op, input xlen_t a,
                      input xlen_t b, input int stall);
  xlen_t exp;
  xlen_t held;
  int    lat;
  exp = ref_result(op, a, b);
  @(negedge clk);
  i_valid = 1'b1;
  i_op    = op;
  i_rs1   = a;
  i_rs2   = b;
  i_ready = (stall == 0);
  lat     = 1;
  #1;
  while (!o_valid) begin
    @(negedge clk);
    #1;
    lat++;
  end
  if (is_special(op, a, b)) begin
    check_eq({name, " latency"}, LAT_SPECIAL, lat);
  end else if (!is_div_op(op)) begin
    check_eq({name, " latency"}, LAT_MUL, lat);
  end else if (lat != LAT_DIV_CORR) begin
    // Divide retires at the check cycle unless both corrections ran
    check_eq({name, " latency"}, LAT_DIV, lat);
  end
  // Waiting at the result point
  held = o_result;
  for (int k = 0; k < stall; k++) begin
    check_eq({name, " stall valid"}, 1, o_valid);
    check_eq({name, " stall ready"}, 0, o_ready);
    check_eq({name, " stall result"}, held, o_result);
    @(negedge clk);
    if (k == stall - 1) i_ready = 1'b1;
    #1;
  end
  check_eq({name, " valid"}, 1, o_valid);
  check_eq({name, " ready"}, 1, o_ready);
  check_eq({name, " result"}, exp, o_result);
  // Retires on this edge
  @(posedge clk);
endtask

//////////////////////////////////////////////////
// Directed tests
//////////////////////////////////////////////////

task automatic reset_outputs_quiet();
  for (int k = 0; k < 4; k++) begin
    @(negedge clk);
    // Divide by zero operands would answer at once if they were presented
    i_op    = k[1] ? OP_DIV : OP_MUL;
    i_rs2   = k[1] ? 32'h0 : 32'h1;
    i_ready = k[0];
    #1;
    check_eq("reset valid", 0, o_valid);
    check_eq("reset ready", 0, o_ready);
  end
endtask

task automatic multiply_ops();
  xlen_t      corner [5];
  muldiv_op_e op;
  xlen_t      a;
  xlen_t      b;
  corner = '{32'h0, 32'h1, 32'hFFFF_FFFF, 32'h8000_0000, 32'h7FFF_FFFF};
  for (int k = 0; k < 4; k++) begin
    op = muldiv_op_e'(k);
    foreach (corner[i]) begin
      foreach (corner[j]) begin
        run_op({"mul corner ", op.name()}, op, corner[i], corner[j], 0);
      end
    end
    for (int n = 0; n < N_RAND; n++) begin
      a = rand_word();
      b = rand_word();
      run_op({"mul random ", op.name()}, op, a, b, 0);
    end
  end
endtask

task automatic divide_ops();
  xlen_t      dvd [7];
  xlen_t      dvs [6];
  muldiv_op_e op;
  xlen_t      a;
  xlen_t      b;
  // Mixed signs with exact and inexact quotients
  dvd = '{32'h0, 32'h1, 32'hFFFF_FFFF, 32'h8000_0000, 32'h7FFF_FFFF, 32'd7, -32'sd7};
  dvs = '{32'h1, 32'hFFFF_FFFF, 32'h8000_0000, 32'h7FFF_FFFF, 32'd3, -32'sd3};
  for (int k = 4; k < 8; k++) begin
    op = muldiv_op_e'(k);
    foreach (dvd[i]) begin
      foreach (dvs[j]) begin
        run_op({"div corner ", op.name()}, op, dvd[i], dvs[j], 0);
      end
    end
    for (int n = 0; n < N_RAND; n++) begin
      a = rand_word();
      b = rand_divisor();
      run_op({"div random ", op.name()}, op, a, b, 0);
    end
  end
endtask

task automatic special_cases();
  muldiv_op_e op;
  for (int k = 4; k < 8; k++) begin
    op = muldiv_op_e'(k);
    run_op({"div by zero ", op.name()}, op, 32'h1234_5678, 32'h0, 0);
    run_op({"div by zero ", op.name()}, op, 32'h8000_0000, 32'h0, 0);
    run_op({"div by zero ", op.name()}, op, 32'hFFFF_FFFF, 32'h0, 0);
    // Overflow for the signed pair and a plain divide for the unsigned one
    run_op({"overflow ", op.name()}, op, 32'h8000_0000, 32'hFFFF_FFFF, 0);
  end
endtask

task automatic back_pressure();
  muldiv_op_e op;
  xlen_t      a;
  xlen_t      b;
  int         stall;
  for (int n = 0; n < N_STALL; n++) begin
    op    = muldiv_op_e'(n);
    a     = rand_word();
    b     = rand_divisor();
    stall = 1 + rand_bits(3);
    run_op({"stall ", op.name()}, op, a, b, stall);
  end
endtask

// Multiply and divide in turn with no idle cycle in between
task automatic chained_ops();
  muldiv_op_e op;
  xlen_t      a;
  xlen_t      b;
  for (int n = 0; n < N_CHAIN; n++) begin
    op = n[0] ? muldiv_op_e'(4 + rand_bits(2)) : muldiv_op_e'(rand_bits(2));
    a  = rand_word();
    b  = rand_divisor();
    run_op({"chain ", op.name()}, op, a, b, 0);
  end
endtask

`endif

// ==== bench/tb_muldiv.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_muldiv import muldiv_pkg::*; ();

  localparam int CLK_PERIOD = 8;
  localparam int RST_CYCLES = 16;

  // LFSR seed and x^32 + x^22 + x^2 + x + 1 feedback taps
  localparam logic [31:0] LFSR_SEED = 32'd11;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  // Result cycle counted from the cycle the operation is first seen in idle
  localparam int LAT_SPECIAL  = 1;
  localparam int LAT_MUL      = 17;
  localparam int LAT_DIV      = 34;
  localparam int LAT_DIV_CORR = 36;

  // Operation counts per test
  localparam int N_RAND       = 20;
  localparam int N_MUL_CORNER = 4 * 5 * 5;
  localparam int N_DIV_CORNER = 4 * 7 * 6;
  localparam int N_SPECIAL    = 4 * 4;
  localparam int N_STALL      = 8;
  localparam int N_CHAIN      = 8;
  localparam int N_OPS        = N_MUL_CORNER + N_DIV_CORNER + 8 * N_RAND
                              + N_SPECIAL + N_STALL + N_CHAIN;

  // Budget of 40 cycles per operation
  localparam longint WATCHDOG_NS = longint'(N_OPS) * 40 * CLK_PERIOD;

  logic       clk;
  logic       i_rst_n;
  logic       i_valid;
  logic       o_ready;
  muldiv_op_e i_op;
  xlen_t      i_rs1;
  xlen_t      i_rs2;
  logic       o_valid;
  logic       i_ready;
  xlen_t      o_result;

  logic [31:0] lfsr;
  int          errors;

  muldiv_unit u_dut (
    .clk      (clk),
    .i_rst_n  (i_rst_n),
    .i_valid  (i_valid),
    .o_ready  (o_ready),
    .i_op     (i_op),
    .i_rs1    (i_rs1),
    .i_rs2    (i_rs2),
    .o_valid  (o_valid),
    .i_ready  (i_ready),
    .o_result (o_result)
  );

  `include "tb_muldiv_tasks.svh"

  //////////////////////////////////////////////////
  // Clock and watchdog
  //////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired: the operations did not all complete in time");
    $display("Test failures found");
    $fatal(1, "simulation stopped by watchdog");
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    // All inputs idle until reset is released
    i_rst_n = 1'b0;
    i_valid = 1'b0;
    i_op    = OP_MUL;
    i_rs1   = '0;
    i_rs2   = 32'h1;
    i_ready = 1'b0;
    lfsr    = LFSR_SEED;
    errors  = 0;

    repeat (RST_CYCLES) @(negedge clk);
    i_rst_n = 1'b1;

    reset_outputs_quiet();
    multiply_ops();
    divide_ops();
    special_cases();
    back_pressure();
    chained_ops();

    // Drop the request once everything has retired
    @(negedge clk);
    i_valid = 1'b0;
    i_ready = 1'b0;
    @(negedge clk);

    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+bench
hw/muldiv_pkg.sv
hw/muldiv_step_if.sv
hw/muldiv_fsm.sv
hw/muldiv_step_counter.sv
hw/booth_mul_path.sv
hw/nonrestore_div_path.sv
hw/muldiv_unit.sv
bench/tb_muldiv.sv
